// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dual_issue_exe_tb -Mdir obj_dir -f dual_issue_exe.f
	./obj_dir/Vdual_issue_exe_tb

clean:
	rm -rf obj_dir

// File: dual_issue_exe.f
verilog/rv_core_types_pkg.sv
verilog/rv_issue_pkg.sv
verilog/issue_steer.sv
verilog/alu_exec.sv
verilog/decode_exe.sv
verilog/dual_issue_exe.sv
verif/dual_issue_exe_asserts.sv
verif/dual_issue_exe_tb.sv

// File: verif/dual_issue_exe_asserts.sv
/* concurrent checks bound into decode_exe
   watches the chose codes, the stops and the registered unit entries */
`default_nettype none

module dual_issue_exe_asserts (
    input wire                               clk,
    input wire                               arst_n,
    input wire rv_core_types_pkg::unit_sel_t chose1,
    input wire rv_core_types_pkg::unit_sel_t chose2,
    input wire                               stop_alu1,
    input wire                               stop_alu2,
    input wire                               stop_mem,
    input wire rv_core_types_pkg::pc_t       alu1_pc,
    input wire rv_core_types_pkg::xdata_t    alu1_op1,
    input wire                               alu1_rd_ena,
    input wire rv_core_types_pkg::pc_t       alu2_pc,
    input wire rv_core_types_pkg::xdata_t    alu2_op1,
    input wire                               alu2_rd_ena,
    input wire rv_core_types_pkg::pc_t       mem_pc,
    input wire rv_core_types_pkg::xdata_t    mem_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv_issue_pkg::*;

    a_distinct_units: assert property (@(posedge clk) disable iff (!arst_n)
        chose1 != UNIT_NONE |-> chose1 != chose2)
        else $error("both slots were steered to the same unit");

    // bit order of the stops follows the one-hot unit codes
    a_stopped_not_chosen: assert property (@(posedge clk) disable iff (!arst_n)
        ((chose1 | chose2) & {stop_mem, stop_alu2, stop_alu1}) == 3'b000)
        else $error("a stopped unit was chosen");

    a_alu1_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stop_alu1 |=> $stable({alu1_pc, alu1_op1, alu1_rd_ena}))
        else $error("alu1 entry changed while stopped");

    a_alu2_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stop_alu2 |=> $stable({alu2_pc, alu2_op1, alu2_rd_ena}))
        else $error("alu2 entry changed while stopped");

    a_mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stop_mem |=> $stable({mem_pc, mem_addr}))
        else $error("memory entry changed while stopped");

endmodule

bind decode_exe dual_issue_exe_asserts asserts_i (
    .clk (clk), .arst_n (arst_n), .chose1 (chose1), .chose2 (chose2),
    .stop_alu1 (stop_alu1), .stop_alu2 (stop_alu2), .stop_mem (stop_mem),
    .alu1_pc (alu1_pc), .alu1_op1 (alu1_op1), .alu1_rd_ena (alu1_rd_ena),
    .alu2_pc (alu2_pc), .alu2_op1 (alu2_op1), .alu2_rd_ena (alu2_rd_ena),
    .mem_pc (mem_pc), .mem_addr (mem_addr)
);

`default_nettype wire

// File: verif/dual_issue_exe_tb.sv
/* pattern-driven testbench for dual_issue_exe, run from the project root
   pcs in the pattern file must be unique, the second pass adds 'h10000 to each */
`default_nettype none

module dual_issue_exe_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_core_types_pkg::*;
    import rv_issue_pkg::*;

    localparam int MAX_INSTR = 64;
    localparam int RUN_LIMIT = 2000;

    logic clk = 1'b0;
    logic arst_n;
    logic slot1_valid, slot2_valid, rd_ena1, rd_ena2;
    logic stop_alu1, stop_alu2, stop_mem;
    inst_class_t class1, class2;
    alu_op_t     opcode1, opcode2;
    xdata_t      op1_1, op2_1, op1_2, op2_2, mem_offset1, mem_offset2;
    reg_addr_t   rd_addr1, rd_addr2;
    pc_t         pc1, pc2;
    inst_t       inst1, inst2;
    mem_sel_t    mem_sel1, mem_sel2;

    logic        slot1_taken, slot2_taken, alu1_wb_valid, alu2_wb_valid, mem_req, mem_rd_ena;
    reg_addr_t   alu1_wb_rd_addr, alu2_wb_rd_addr, mem_rd_addr;
    xdata_t      alu1_wb_data, alu2_wb_data, mem_wdata, mem_addr;
    pc_t         alu1_wb_pc, alu2_wb_pc, mem_pc;
    inst_t       mem_inst;
    mem_sel_t    mem_sel;

    // instruction stream from the pattern file, invalid slots dropped
    inst_class_t t_cls [MAX_INSTR];
    alu_op_t     t_op  [MAX_INSTR];
    xdata_t      t_op1 [MAX_INSTR];
    xdata_t      t_op2 [MAX_INSTR];
    xdata_t      t_off [MAX_INSTR];
    xdata_t      t_exp [MAX_INSTR];
    mem_sel_t    t_msel[MAX_INSTR];
    reg_addr_t   t_rd  [MAX_INSTR];
    pc_t         t_pc  [MAX_INSTR];
    int          n_instr = 0;
    int          head;
    int          cycle = 0;

    // outstanding results keyed by pc
    xdata_t    exp_val  [pc_t];
    xdata_t    exp_wdata[pc_t];
    mem_sel_t  exp_msel [pc_t];
    reg_addr_t exp_rd   [pc_t];
    unit_sel_t exp_unit [pc_t];
    int        exp_take [pc_t];
    pc_t       mem_order[$];      // the single memory port keeps program order

    dual_issue_exe dut_i (.*);

    always #2 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, what));
    endtask

    task automatic check_xdata(input string name, input xdata_t got, input xdata_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_mem_sel(input string name, input mem_sel_t got, input mem_sel_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_unit(input string name, input unit_sel_t got, input unit_sel_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic load_patterns();
        int          fd;
        int          b;
        string       line;
        logic [63:0] f [20];
        fd = $fopen("verif/dual_issue_patterns.txt", "r");
        if (fd == 0)
            abort_run("cannot open the pattern file verif/dual_issue_patterns.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line[0] == "#")
                continue;
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]) != 20)
                abort_run($sformatf("malformed pattern line: %s", line));
            for (int s = 0; s < 2; s++) begin
                b = s * 10;
                if (f[b] != 0) begin
                    t_cls[n_instr]  = f[b+1][7:0];
                    t_op[n_instr]   = f[b+2][7:0];
                    t_op1[n_instr]  = f[b+3];
                    t_op2[n_instr]  = f[b+4];
                    t_off[n_instr]  = f[b+5];
                    t_msel[n_instr] = f[b+6][2:0];
                    t_rd[n_instr]   = f[b+7][4:0];
                    t_pc[n_instr]   = f[b+8];
                    t_exp[n_instr]  = f[b+9];
                    n_instr++;
                end
            end
        end
        $fclose(fd);
    endtask

    // in-order steering as the issue rules describe it
    function automatic unit_sel_t pick_unit(input inst_class_t cls, input unit_sel_t free);
        if (cls == CLASS_ALU && free[0])
            return UNIT_ALU1;
        if (cls == CLASS_ALU && free[1])
            return UNIT_ALU2;
        if (cls == CLASS_MEM && free[2])
            return UNIT_MEM;
        return UNIT_NONE;
    endfunction

    function automatic logic [279:0] slot_fields(input int idx, input pc_t base, input logic valid);
        if (!valid)
            return '0;
        return {t_cls[idx], t_op[idx], t_op1[idx], t_op2[idx], t_off[idx], t_msel[idx],
                t_rd[idx], t_pc[idx] + base};
    endfunction

    task automatic expect_entry(input int idx, input pc_t base, input unit_sel_t unit);
        pc_t key;
        key             = t_pc[idx] + base;
        exp_val[key]    = t_exp[idx];
        exp_wdata[key]  = t_op2[idx];
        exp_msel[key]   = t_msel[idx];
        exp_rd[key]     = t_rd[idx];
        exp_unit[key]   = unit;
        exp_take[key]   = cycle;
        if (unit == UNIT_MEM)
            mem_order.push_back(key);
    endtask

    task automatic forget(input pc_t key);
        exp_val.delete(key);
        exp_wdata.delete(key);
        exp_msel.delete(key);
        exp_rd.delete(key);
        exp_unit.delete(key);
        exp_take.delete(key);
    endtask

    task automatic retire_alu(input unit_sel_t unit, input pc_t pc, input reg_addr_t rd,
                              input xdata_t data, input logic timed);
        if (!exp_val.exists(pc))
            abort_run($sformatf("write-back for pc %h was not expected or came twice", pc));
        check_unit("write-back unit", unit, exp_unit[pc]);
        check_reg_addr("wb_rd_addr", rd, exp_rd[pc]);
        check_xdata("wb_data", data, exp_val[pc]);
        if (timed && cycle - exp_take[pc] != 2)
            report_mismatch($sformatf("pc %h wrote back %0d cycles after issue",
                                      pc, cycle - exp_take[pc]));
        forget(pc);
    endtask

    task automatic retire_mem(input logic timed);
        pc_t key;
        if (mem_order.size() == 0)
            abort_run("a memory request appeared with none outstanding");
        key = mem_order.pop_front();
        check_pc("mem_pc", mem_pc, key);
        check_inst("mem_inst", mem_inst, key[31:0] ^ 32'h13);
        check_level("mem_rd_ena", mem_rd_ena, 1'b1);
        check_xdata("mem_addr", mem_addr, exp_val[key]);
        check_xdata("mem_wdata", mem_wdata, exp_wdata[key]);
        check_mem_sel("mem_sel", mem_sel, exp_msel[key]);
        check_reg_addr("mem_rd_addr", mem_rd_addr, exp_rd[key]);
        if (timed && cycle - exp_take[key] != 1)
            report_mismatch($sformatf("pc %h reached the memory port %0d cycles after issue",
                                      key, cycle - exp_take[key]));
        forget(key);
    endtask

    task automatic run_pass(input pc_t base, input logic random_stops);
        int        guard;
        unit_sel_t free;
        unit_sel_t u1;
        unit_sel_t u2;
        head  = 0;
        guard = 0;
        while (head < n_instr || exp_val.num() != 0) begin
            guard++;
            if (guard > RUN_LIMIT)
                abort_run("timeout while instructions were still outstanding");
            @(posedge clk);
            #1;
            slot1_valid = head < n_instr;
            slot2_valid = head + 1 < n_instr;
            {class1, opcode1, op1_1, op2_1, mem_offset1, mem_sel1, rd_addr1, pc1} =
                slot_fields(head, base, slot1_valid);
            {class2, opcode2, op1_2, op2_2, mem_offset2, mem_sel2, rd_addr2, pc2} =
                slot_fields(head + 1, base, slot2_valid);
            inst1     = pc1[31:0] ^ 32'h13;
            inst2     = pc2[31:0] ^ 32'h13;
            rd_ena1   = slot1_valid;
            rd_ena2   = slot2_valid;
            stop_alu1 = random_stops && $urandom_range(3) == 0;
            stop_alu2 = random_stops && $urandom_range(3) == 0;
            stop_mem  = random_stops && $urandom_range(3) == 0;
            free = ~{stop_mem, stop_alu2, stop_alu1};
            u1 = slot1_valid ? pick_unit(class1, free) : UNIT_NONE;
            u2 = (slot2_valid && u1 != UNIT_NONE) ? pick_unit(class2, free & ~u1) : UNIT_NONE;
            @(negedge clk);     // combinational and registered outputs are settled here
            check_level("slot1_taken", slot1_taken, u1 != UNIT_NONE);
            check_level("slot2_taken", slot2_taken, u2 != UNIT_NONE);
            if (u1 != UNIT_NONE) begin
                expect_entry(head, base, u1);
                head++;
            end
            if (u2 != UNIT_NONE) begin
                expect_entry(head, base, u2);
                head++;
            end
            if (alu1_wb_valid)
                retire_alu(UNIT_ALU1, alu1_wb_pc, alu1_wb_rd_addr, alu1_wb_data, !random_stops);
            if (alu2_wb_valid)
                retire_alu(UNIT_ALU2, alu2_wb_pc, alu2_wb_rd_addr, alu2_wb_data, !random_stops);
            if (mem_req && !stop_mem)
                retire_mem(!random_stops);   // a held request counts once, in the cycle it leaves
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            slot1_valid = 1'b0;
            slot2_valid = 1'b0;
            stop_alu1   = 1'b0;
            stop_alu2   = 1'b0;
            stop_mem    = 1'b0;
            @(negedge clk);
            if (slot1_taken || slot2_taken || alu1_wb_valid || alu2_wb_valid || mem_req)
                abort_run("the DUT showed activity while both slots were idle");
        end
    endtask

    initial begin
        void'($urandom(32'hc0c7));
        arst_n      = 1'b0;
        slot1_valid = 1'b0;
        slot2_valid = 1'b0;
        stop_alu1   = 1'b0;
        stop_alu2   = 1'b0;
        stop_mem    = 1'b0;
        {class1, opcode1, op1_1, op2_1, mem_offset1, mem_sel1, rd_addr1, pc1} = '0;
        {class2, opcode2, op1_2, op2_2, mem_offset2, mem_sel2, rd_addr2, pc2} = '0;
        {rd_ena1, rd_ena2, inst1, inst2} = '0;
        load_patterns();
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        check_idle(4);
        run_pass(pc_t'(0), 1'b0);
        run_pass(pc_t'(64'h10000), 1'b1);
        check_idle(4);
        if (exp_val.num() != 0 || mem_order.size() != 0) begin
            abort_run("results were still outstanding at the end of the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/dual_issue_patterns.txt
# per slot, in hex: valid class opcode op1 op2 offset mem_sel rd pc expected, slot 1 then slot 2
# class 1 is ALU with expected result, class 2 is MEM with expected address op1 + offset
1 1 1 5 3 0 0 1 1000 8   1 1 2 5 3 0 0 2 1004 2
1 1 3 f0f0 ff00 0 0 3 1008 f000   1 1 4 f0f0 0f0f 0 0 4 100c ffff
1 1 5 ff f 0 0 5 1010 f0   1 1 6 1 3f 0 0 6 1014 8000000000000000
1 1 7 8000000000000000 3f 0 0 7 1018 1   1 1 8 ffffffffffffffff 1 0 0 8 101c 1
1 1 8 1 ffffffffffffffff 0 0 9 1020 0   1 1 2 0 1 0 0 a 1024 ffffffffffffffff
1 2 0 2000 aa 10 3 b 1028 2010   1 2 0 3000 bb 8 2 c 102c 3008
1 1 1 7 8 0 0 d 1030 f   1 2 0 4000 cc 4 1 e 1034 4004
1 2 0 5000 dd 0 0 f 1038 5000   1 1 4 1 2 0 0 10 103c 3
1 1 1 1 1 0 0 11 1040 2   0 0 0 0 0 0 0 0 0 0
1 1 6 1 41 0 0 12 1044 2   1 1 1 ffffffffffffffff 2 0 0 13 1048 1
1 1 7 f0 44 0 0 14 104c f   1 1 5 aaaa 5555 0 0 15 1050 ffff
1 2 0 6000 ee 20 5 16 1054 6020   1 2 0 7000 ff 0 6 17 1058 7000
1 1 3 ff00ff 0ff0 0 0 18 105c f0   1 1 2 10 20 0 0 19 1060 fffffffffffffff0

// File: verilog/alu_exec.sv
/* registered RV64 integer ALU, one write-back request per unstalled entry
   shifts use op2[5:0], an unknown opcode writes zero */
`default_nettype none

module alu_exec (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire                                 stop,
    input  wire                                 rd_ena,
    input  wire rv_core_types_pkg::reg_addr_t   rd_addr,
    input  wire rv_core_types_pkg::pc_t         pc,
    input  wire rv_core_types_pkg::alu_op_t     opcode,
    input  wire rv_core_types_pkg::xdata_t      op1,
    input  wire rv_core_types_pkg::xdata_t      op2,
    output logic                                wb_valid,
    output rv_core_types_pkg::reg_addr_t        wb_rd_addr,
    output rv_core_types_pkg::xdata_t           wb_data,
    output rv_core_types_pkg::pc_t              wb_pc
);
    import rv_core_types_pkg::*;
    import rv_issue_pkg::*;

    xdata_t     result;
    logic [5:0] shamt;
    logic       fire;

    assign shamt = op2[5:0];
    assign fire  = rd_ena && !stop;   // the dispatch register holds the entry while stopped

    always_comb begin
        case (opcode)
            OP_ADD:  result = op1 + op2;
            OP_SUB:  result = op1 - op2;
            OP_AND:  result = op1 & op2;
            OP_OR:   result = op1 | op2;
            OP_XOR:  result = op1 ^ op2;
            OP_SLL:  result = op1 << shamt;
            OP_SRL:  result = op1 >> shamt;
            OP_SLT:  result = xdata_t'($signed(op1) < $signed(op2));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid   <= 1'b0;
            wb_rd_addr <= '0;
            wb_data    <= '0;
            wb_pc      <= '0;
        end else begin
            wb_valid <= fire;   // single-cycle pulse
            if (fire) begin
                wb_rd_addr <= rd_addr;
                wb_data    <= result;
                wb_pc      <= pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_exe.sv
/* dispatch registers for alu1, alu2 and the load/store port
   chose is trusted as given, each register holds on its own stop
   the memory address is op1 plus the slot offset, formed before capture */
`default_nettype none

module decode_exe (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire rv_core_types_pkg::unit_sel_t   chose1,
    input  wire rv_core_types_pkg::unit_sel_t   chose2,
    input  wire                                 stop_alu1,
    input  wire                                 stop_alu2,
    input  wire                                 stop_mem,

    input  wire rv_core_types_pkg::inst_class_t class1,
    input  wire rv_core_types_pkg::alu_op_t     opcode1,
    input  wire rv_core_types_pkg::xdata_t      op1_1,
    input  wire rv_core_types_pkg::xdata_t      op2_1,
    input  wire                                 rd_ena1,
    input  wire rv_core_types_pkg::reg_addr_t   rd_addr1,
    input  wire rv_core_types_pkg::pc_t         pc1,
    input  wire rv_core_types_pkg::inst_t       inst1,
    input  wire rv_core_types_pkg::xdata_t      mem_offset1,
    input  wire rv_core_types_pkg::mem_sel_t    mem_sel1,

    input  wire rv_core_types_pkg::inst_class_t class2,
    input  wire rv_core_types_pkg::alu_op_t     opcode2,
    input  wire rv_core_types_pkg::xdata_t      op1_2,
    input  wire rv_core_types_pkg::xdata_t      op2_2,
    input  wire                                 rd_ena2,
    input  wire rv_core_types_pkg::reg_addr_t   rd_addr2,
    input  wire rv_core_types_pkg::pc_t         pc2,
    input  wire rv_core_types_pkg::inst_t       inst2,
    input  wire rv_core_types_pkg::xdata_t      mem_offset2,
    input  wire rv_core_types_pkg::mem_sel_t    mem_sel2,

    output rv_core_types_pkg::inst_t            alu1_inst,
    output rv_core_types_pkg::pc_t              alu1_pc,
    output rv_core_types_pkg::inst_class_t      alu1_inst_class,
    output rv_core_types_pkg::alu_op_t          alu1_opcode,
    output rv_core_types_pkg::xdata_t           alu1_op1,
    output rv_core_types_pkg::xdata_t           alu1_op2,
    output logic                                alu1_rd_ena,
    output rv_core_types_pkg::reg_addr_t        alu1_rd_addr,

    output rv_core_types_pkg::inst_t            alu2_inst,
    output rv_core_types_pkg::pc_t              alu2_pc,
    output rv_core_types_pkg::inst_class_t      alu2_inst_class,
    output rv_core_types_pkg::alu_op_t          alu2_opcode,
    output rv_core_types_pkg::xdata_t           alu2_op1,
    output rv_core_types_pkg::xdata_t           alu2_op2,
    output logic                                alu2_rd_ena,
    output rv_core_types_pkg::reg_addr_t        alu2_rd_addr,

    output rv_core_types_pkg::inst_t            mem_inst,
    output rv_core_types_pkg::pc_t              mem_pc,
    output rv_core_types_pkg::inst_class_t      mem_class,
    output logic                                mem_rd_ena,
    output rv_core_types_pkg::reg_addr_t        mem_rd_addr,
    output rv_core_types_pkg::xdata_t           mem_wdata,
    output rv_core_types_pkg::xdata_t           mem_addr,
    output rv_core_types_pkg::mem_sel_t         mem_sel
);
    import rv_core_types_pkg::*;
    import rv_issue_pkg::*;

    localparam int ALU_W = $bits(inst_t) + $bits(pc_t) + $bits(inst_class_t)
                         + $bits(alu_op_t) + 2 * $bits(xdata_t) + 1 + $bits(reg_addr_t);
    localparam int MEM_W = $bits(inst_t) + $bits(pc_t) + $bits(inst_class_t) + 1
                         + $bits(reg_addr_t) + 2 * $bits(xdata_t) + $bits(mem_sel_t);

    logic [ALU_W-1:0] slot1_alu, slot2_alu;
    logic [ALU_W-1:0] alu1_d, alu1_q;
    logic [ALU_W-1:0] alu2_d, alu2_q;
    logic [MEM_W-1:0] slot1_mem, slot2_mem;
    logic [MEM_W-1:0] mem_d, mem_q;

    assign slot1_alu = {inst1, pc1, class1, opcode1, op1_1, op2_1, rd_ena1, rd_addr1};
    assign slot2_alu = {inst2, pc2, class2, opcode2, op1_2, op2_2, rd_ena2, rd_addr2};

    // op2 is the store data
    assign slot1_mem = {inst1, pc1, class1, rd_ena1, rd_addr1, op2_1,
                        op1_1 + mem_offset1, mem_sel1};
    assign slot2_mem = {inst2, pc2, class2, rd_ena2, rd_addr2, op2_2,
                        op1_2 + mem_offset2, mem_sel2};

    // an unchosen unit takes an all-zero bubble
    assign alu1_d = (chose1 == UNIT_ALU1) ? slot1_alu :
                    (chose2 == UNIT_ALU1) ? slot2_alu : '0;
    assign alu2_d = (chose1 == UNIT_ALU2) ? slot1_alu :
                    (chose2 == UNIT_ALU2) ? slot2_alu : '0;
    assign mem_d  = (chose1 == UNIT_MEM)  ? slot1_mem :
                    (chose2 == UNIT_MEM)  ? slot2_mem : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu1_q <= '0;
            alu2_q <= '0;
            mem_q  <= '0;
        end else begin
            if (!stop_alu1)
                alu1_q <= alu1_d;   // a stopped unit keeps its entry
            if (!stop_alu2)
                alu2_q <= alu2_d;
            if (!stop_mem)
                mem_q  <= mem_d;
        end
    end

    assign {alu1_inst, alu1_pc, alu1_inst_class, alu1_opcode,
            alu1_op1, alu1_op2, alu1_rd_ena, alu1_rd_addr} = alu1_q;
    assign {alu2_inst, alu2_pc, alu2_inst_class, alu2_opcode,
            alu2_op1, alu2_op2, alu2_rd_ena, alu2_rd_addr} = alu2_q;
    assign {mem_inst, mem_pc, mem_class, mem_rd_ena, mem_rd_addr,
            mem_wdata, mem_addr, mem_sel} = mem_q;

endmodule

`default_nettype wire

// File: verilog/dual_issue_exe.sv
/* dual-issue decode to execute boundary with two ALUs and one load/store port
   slots not taken must be re-presented by decode on the next cycle */
`default_nettype none

module dual_issue_exe (
    input  wire                                 clk,
    input  wire                                 arst_n,

    input  wire                                 slot1_valid,
    input  wire rv_core_types_pkg::inst_class_t class1,
    input  wire rv_core_types_pkg::alu_op_t     opcode1,
    input  wire rv_core_types_pkg::xdata_t      op1_1,
    input  wire rv_core_types_pkg::xdata_t      op2_1,
    input  wire                                 rd_ena1,
    input  wire rv_core_types_pkg::reg_addr_t   rd_addr1,
    input  wire rv_core_types_pkg::pc_t         pc1,
    input  wire rv_core_types_pkg::inst_t       inst1,
    input  wire rv_core_types_pkg::xdata_t      mem_offset1,
    input  wire rv_core_types_pkg::mem_sel_t    mem_sel1,

    input  wire                                 slot2_valid,
    input  wire rv_core_types_pkg::inst_class_t class2,
    input  wire rv_core_types_pkg::alu_op_t     opcode2,
    input  wire rv_core_types_pkg::xdata_t      op1_2,
    input  wire rv_core_types_pkg::xdata_t      op2_2,
    input  wire                                 rd_ena2,
    input  wire rv_core_types_pkg::reg_addr_t   rd_addr2,
    input  wire rv_core_types_pkg::pc_t         pc2,
    input  wire rv_core_types_pkg::inst_t       inst2,
    input  wire rv_core_types_pkg::xdata_t      mem_offset2,
    input  wire rv_core_types_pkg::mem_sel_t    mem_sel2,

    input  wire                                 stop_alu1,
    input  wire                                 stop_alu2,
    input  wire                                 stop_mem,
    output logic                                slot1_taken,
    output logic                                slot2_taken,

    output logic                                alu1_wb_valid,
    output rv_core_types_pkg::reg_addr_t        alu1_wb_rd_addr,
    output rv_core_types_pkg::xdata_t           alu1_wb_data,
    output rv_core_types_pkg::pc_t              alu1_wb_pc,
    output logic                                alu2_wb_valid,
    output rv_core_types_pkg::reg_addr_t        alu2_wb_rd_addr,
    output rv_core_types_pkg::xdata_t           alu2_wb_data,
    output rv_core_types_pkg::pc_t              alu2_wb_pc,

    output logic                                mem_req,
    output rv_core_types_pkg::inst_t            mem_inst,
    output rv_core_types_pkg::pc_t              mem_pc,
    output logic                                mem_rd_ena,
    output rv_core_types_pkg::reg_addr_t        mem_rd_addr,
    output rv_core_types_pkg::xdata_t           mem_wdata,
    output rv_core_types_pkg::xdata_t           mem_addr,
    output rv_core_types_pkg::mem_sel_t         mem_sel
);
    import rv_core_types_pkg::*;

    unit_sel_t   chose1, chose2;
    inst_class_t mem_class;
    pc_t         alu1_pc, alu2_pc;
    alu_op_t     alu1_opcode, alu2_opcode;
    xdata_t      alu1_op1, alu1_op2, alu2_op1, alu2_op2;
    logic        alu1_rd_ena, alu2_rd_ena;
    reg_addr_t   alu1_rd_addr, alu2_rd_addr;

    issue_steer steer_i (.*);

    // the ALUs need neither the instruction word nor its class
    decode_exe dec_exe_i (
        .alu1_inst       (),
        .alu1_inst_class (),
        .alu2_inst       (),
        .alu2_inst_class (),
        .*
    );

    alu_exec alu1_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .stop       (stop_alu1),
        .rd_ena     (alu1_rd_ena),
        .rd_addr    (alu1_rd_addr),
        .pc         (alu1_pc),
        .opcode     (alu1_opcode),
        .op1        (alu1_op1),
        .op2        (alu1_op2),
        .wb_valid   (alu1_wb_valid),
        .wb_rd_addr (alu1_wb_rd_addr),
        .wb_data    (alu1_wb_data),
        .wb_pc      (alu1_wb_pc)
    );

    alu_exec alu2_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .stop       (stop_alu2),
        .rd_ena     (alu2_rd_ena),
        .rd_addr    (alu2_rd_addr),
        .pc         (alu2_pc),
        .opcode     (alu2_opcode),
        .op1        (alu2_op1),
        .op2        (alu2_op2),
        .wb_valid   (alu2_wb_valid),
        .wb_rd_addr (alu2_wb_rd_addr),
        .wb_data    (alu2_wb_data),
        .wb_pc      (alu2_wb_pc)
    );

    // bubbles carry a zero class, a captured MEM entry never does
    assign mem_req = (mem_class != '0);

endmodule

`default_nettype wire

// File: verilog/issue_steer.sv
/* purely combinational unit choice for the two decoded slots
   slot 2 issues only behind slot 1, and a stopped unit is never chosen */
`default_nettype none

module issue_steer (
    input  wire                                 slot1_valid,
    input  wire                                 slot2_valid,
    input  wire rv_core_types_pkg::inst_class_t class1,
    input  wire rv_core_types_pkg::inst_class_t class2,
    input  wire                                 stop_alu1,
    input  wire                                 stop_alu2,
    input  wire                                 stop_mem,
    output rv_core_types_pkg::unit_sel_t        chose1,
    output rv_core_types_pkg::unit_sel_t        chose2,
    output logic                                slot1_taken,
    output logic                                slot2_taken
);
    import rv_core_types_pkg::*;
    import rv_issue_pkg::*;

    unit_sel_t free1;   // units able to accept slot 1
    unit_sel_t free2;   // what slot 1 left over

    assign free1 = ~{stop_mem, stop_alu2, stop_alu1};   // bit order follows the one-hot codes
    assign free2 = free1 & ~chose1;

    always_comb begin
        chose1 = UNIT_NONE;
        if (slot1_valid) begin
            if (class1 == CLASS_ALU) begin
                if (|(free1 & UNIT_ALU1))
                    chose1 = UNIT_ALU1;
                else if (|(free1 & UNIT_ALU2))
                    chose1 = UNIT_ALU2;
            end else if (class1 == CLASS_MEM && |(free1 & UNIT_MEM)) begin
                chose1 = UNIT_MEM;
            end
        end
    end

    // slot 2 waits whenever slot 1 waits so issue stays in program order
    always_comb begin
        chose2 = UNIT_NONE;
        if (slot2_valid && chose1 != UNIT_NONE) begin
            if (class2 == CLASS_ALU) begin
                if (|(free2 & UNIT_ALU1))
                    chose2 = UNIT_ALU1;
                else if (|(free2 & UNIT_ALU2))
                    chose2 = UNIT_ALU2;
            end else if (class2 == CLASS_MEM && |(free2 & UNIT_MEM)) begin
                chose2 = UNIT_MEM;
            end
        end
    end

    assign slot1_taken = (chose1 != UNIT_NONE);
    assign slot2_taken = (chose2 != UNIT_NONE);   // decode re-presents whatever was not taken

endmodule

`default_nettype wire

// File: verilog/rv_core_types_pkg.sv
/* width types of the RV64 integer issue path, fixed by the ISA
   unit_sel_t is one-hot and a zero value means no unit */
`default_nettype none

package rv_core_types_pkg;

    typedef logic [63:0] xdata_t;       // register operand or result
    typedef logic [63:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // access size and sign select, passed to the memory stage untouched
    typedef logic [2:0]  mem_sel_t;

    typedef logic [2:0]  unit_sel_t;    // bit 0 alu1, bit 1 alu2, bit 2 mem
    typedef logic [7:0]  inst_class_t;
    typedef logic [7:0]  alu_op_t;

endpackage

`default_nettype wire

// File: verilog/rv_issue_pkg.sv
/* codes shared by steering, the dispatch registers and the ALUs
   a class other than CLASS_ALU or CLASS_MEM is never issued */
`default_nettype none

package rv_issue_pkg;

    import rv_core_types_pkg::*;

    localparam unit_sel_t UNIT_NONE = 3'b000;
    localparam unit_sel_t UNIT_ALU1 = 3'b001;
    localparam unit_sel_t UNIT_ALU2 = 3'b010;
    localparam unit_sel_t UNIT_MEM  = 3'b100;

    // zero is left for the bubble
    localparam inst_class_t CLASS_ALU = 8'h01;
    localparam inst_class_t CLASS_MEM = 8'h02;

    localparam alu_op_t OP_ADD = 8'h01;
    localparam alu_op_t OP_SUB = 8'h02;
    localparam alu_op_t OP_AND = 8'h03;
    localparam alu_op_t OP_OR  = 8'h04;
    localparam alu_op_t OP_XOR = 8'h05;
    localparam alu_op_t OP_SLL = 8'h06;
    localparam alu_op_t OP_SRL = 8'h07;
    localparam alu_op_t OP_SLT = 8'h08;   // signed compare

endpackage

`default_nettype wire
